//--- Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - src
    files:
      - src/exPkg.sv
      - src/operandForward.sv
      - src/aluUnit.sv
      - src/mulDivUnit.sv
      - src/exStageReg.sv
      - src/exStage.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/exStageTb.sv

//--- bench/exStageTb.sv
`timescale 1ns/1ps
`include "exCfg.svh"

module exStageTb;

    localparam int clkPeriod = 10;
    localparam int aluReps = 6;
    localparam int mulLatency = `EX_MUL_CYCLES;
    localparam int divLatency = `EX_DIV_CYCLES;
    localparam int busyWaitMax = divLatency + 4;
    // Sweep, directed cases and every multiply/divide sequence with its wait
    localparam int aluCycles = 28 * aluReps + 3;
    localparam int mdCycles = 14 * (busyWaitMax + 4);
    localparam int directedCycles = 40;
    localparam int watchdogCycles = 4 + aluCycles + mdCycles + directedCycles + 100;

    logic clk;
    logic reset;
    logic stall;
    logic clr;
    logic disMulDiv;
    exPkg::exInT exIn;
    exPkg::fwdT fwdMem;
    exPkg::fwdT fwdWb;
    exPkg::exOutT exMem;
    logic mdBusy;

    // Reference model state
    exPkg::exOutT predicted;
    exPkg::exOutT expMem;
    logic predBusy;
    exPkg::wordT hiModel;
    exPkg::wordT loModel;
    exPkg::wordT predHi;
    exPkg::wordT predLo;
    int countModel;
    int predCount;

    exPkg::fwdT curFwdMem;
    exPkg::fwdT curFwdWb;
    logic curStall;
    logic curClr;
    logic curDis;
    logic checkOn;
    logic [31:0] lfsrState;
    int exMemErrors;
    int busyErrors;
    int otherErrors;

    exStage exStage_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .clr       (clr),
        .disMulDiv (disMulDiv),
        .exIn      (exIn),
        .fwdMem    (fwdMem),
        .fwdWb     (fwdWb),
        .exMem     (exMem),
        .mdBusy    (mdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    function automatic exPkg::iFuncT classOf(input exPkg::instrT op);
        case (op)
            exPkg::ADDI, exPkg::ADDIU, exPkg::ANDI, exPkg::ORI, exPkg::XORI,
            exPkg::SLTI, exPkg::SLTIU, exPkg::LUI: return exPkg::ALU_I;
            exPkg::LW:  return exPkg::MEM_R;
            exPkg::SW:  return exPkg::MEM_W;
            exPkg::NOP: return exPkg::OTHER;
            default:    return (op >= exPkg::MULT) ? exPkg::MULDIV : exPkg::ALU_R;
        endcase
    endfunction

    function automatic exPkg::exInT buildIn(input exPkg::instrT op, input exPkg::wordT rs,
                                            input exPkg::wordT rt, input logic [15:0] imm);
        exPkg::exInT in;
        in = '0;
        in.instr = op;
        in.iFunc = classOf(op);
        in.pc = 32'h0040_0100;
        in.dataRs = rs;
        in.dataRt = rt;
        in.imm16 = imm;
        // Shift amount sits in imm[10:6] as in the instruction word
        in.shamt = imm[10:6];
        in.addrRs = 5'd8;
        in.addrRt = 5'd9;
        in.addrRd = 5'd10;
        in.regWriteAddr = 5'd10;
        in.regWriteData = 32'h0bad_cafe;
        in.tNew = 2'd1;
        return in;
    endfunction

    function automatic exPkg::wordT forwardRef(input exPkg::regAddrT addr,
                                               input exPkg::wordT decoded);
        if (addr == 0) begin
            return decoded;
        end
        if (fwdMem.addr == addr) begin
            return fwdMem.data;
        end
        if (fwdWb.addr == addr) begin
            return fwdWb.data;
        end
        return decoded;
    endfunction

    function automatic exPkg::wordT leadingCount(input exPkg::wordT value, input logic bitVal);
        int n;
        n = 0;
        while (n < 32 && value[31-n] == bitVal) begin
            n++;
        end
        return n;
    endfunction

    function automatic exPkg::wordT aluRef(input exPkg::exInT in, input exPkg::wordT rs,
                                           input exPkg::wordT rt);
        exPkg::wordT sImm;
        exPkg::wordT zImm;
        logic [4:0] sa;
        sImm = {{16{in.imm16[15]}}, in.imm16};
        zImm = {16'h0, in.imm16};
        sa = (in.instr inside {exPkg::SLL, exPkg::SRL, exPkg::SRA}) ? in.shamt : rs[4:0];
        case (in.instr)
            exPkg::ADD, exPkg::ADDU: return rs + rt;
            exPkg::ADDI, exPkg::ADDIU, exPkg::LW, exPkg::SW: return rs + sImm;
            exPkg::SUB, exPkg::SUBU: return rs - rt;
            exPkg::AND:   return rs & rt;
            exPkg::ANDI:  return rs & zImm;
            exPkg::OR:    return rs | rt;
            exPkg::ORI:   return rs | zImm;
            exPkg::XOR:   return rs ^ rt;
            exPkg::XORI:  return rs ^ zImm;
            exPkg::NOR:   return ~(rs | rt);
            exPkg::SLT:   return {31'b0, $signed(rs) < $signed(rt)};
            exPkg::SLTI:  return {31'b0, $signed(rs) < $signed(sImm)};
            exPkg::SLTU:  return {31'b0, rs < rt};
            exPkg::SLTIU: return {31'b0, rs < sImm};
            exPkg::SLL, exPkg::SLLV: return rt << sa;
            exPkg::SRL, exPkg::SRLV: return rt >> sa;
            exPkg::SRA, exPkg::SRAV: return $signed(rt) >>> sa;
            exPkg::LUI:   return {in.imm16, 16'h0};
            exPkg::CLO:   return leadingCount(rs, 1'b1);
            exPkg::CLZ:   return leadingCount(rs, 1'b0);
            default:      return '0;
        endcase
    endfunction

    // Overflow when both addends share a sign that the sum lacks
    function automatic exPkg::excCodeT excRef(input exPkg::exInT in, input exPkg::wordT rs,
                                              input exPkg::wordT rt);
        exPkg::wordT b;
        exPkg::wordT sum;
        exPkg::wordT dif;
        logic addOv;
        logic subOv;
        b = (in.instr == exPkg::ADD) ? rt : {{16{in.imm16[15]}}, in.imm16};
        sum = rs + b;
        dif = rs - rt;
        addOv = (rs[31] == b[31]) && (sum[31] != rs[31]);
        subOv = (rs[31] != rt[31]) && (dif[31] != rs[31]);
        if (in.instr == exPkg::LW && addOv) begin
            return `EX_EXC_ADEL;
        end
        if (in.instr == exPkg::SW && addOv) begin
            return `EX_EXC_ADES;
        end
        if ((in.instr == exPkg::ADD || in.instr == exPkg::ADDI) && addOv) begin
            return `EX_EXC_OV;
        end
        if (in.instr == exPkg::SUB && subOv) begin
            return `EX_EXC_OV;
        end
        return '0;
    endfunction

    task automatic predict();
        exPkg::wordT rs;
        exPkg::wordT rt;
        exPkg::wordT alu;
        exPkg::wordT md;
        exPkg::excCodeT aluExc;
        logic moveFrom;
        logic unsignedOp;
        logic [63:0] prod;
        longint sQuot;
        longint sRem;
        rs = forwardRef(exIn.addrRs, exIn.dataRs);
        rt = forwardRef(exIn.addrRt, exIn.dataRt);
        alu = aluRef(exIn, rs, rt);
        aluExc = excRef(exIn, rs, rt);
        moveFrom = exIn.instr inside {exPkg::MFHI, exPkg::MFLO};
        md = '0;
        if (countModel == 0 && exIn.instr == exPkg::MFHI) begin
            md = hiModel;
        end else if (countModel == 0 && exIn.instr == exPkg::MFLO) begin
            md = loModel;
        end
        predBusy = (countModel != 0) || (exIn.instr inside {exPkg::MULT, exPkg::MULTU,
            exPkg::DIV, exPkg::DIVU, exPkg::MADD, exPkg::MADDU, exPkg::MSUB, exPkg::MSUBU});

        predicted.instr = exIn.instr;
        predicted.iFunc = exIn.iFunc;
        predicted.pc = exIn.pc;
        predicted.exc = (exIn.exc != 0) ? exIn.exc : aluExc;
        predicted.branchDelay = exIn.branchDelay;
        predicted.exOut = moveFrom ? md : alu;
        predicted.addrRt = exIn.addrRt;
        predicted.dataRt = rt;
        predicted.addrRd = exIn.addrRd;
        predicted.regWriteAddr = exIn.regWriteAddr;
        if (moveFrom) begin
            predicted.regWriteData = md;
        end else if (exIn.iFunc == exPkg::ALU_R || exIn.iFunc == exPkg::ALU_I) begin
            predicted.regWriteData = alu;
        end else begin
            predicted.regWriteData = exIn.regWriteData;
        end
        predicted.tNew = (exIn.tNew == 0) ? 2'd0 : exIn.tNew - 2'd1;

        // HI/LO after the coming edge
        unsignedOp = exIn.instr inside {exPkg::MULTU, exPkg::DIVU, exPkg::MADDU, exPkg::MSUBU};
        prod = unsignedOp ? {32'h0, rs} * {32'h0, rt} : longint'($signed(rs)) * longint'($signed(rt));
        predHi = hiModel;
        predLo = loModel;
        predCount = (countModel > 0) ? countModel - 1 : 0;
        if (countModel == 0 && !disMulDiv) begin
            case (exIn.instr)
                exPkg::MULT, exPkg::MULTU: begin
                    {predHi, predLo} = prod;
                    predCount = mulLatency;
                end
                exPkg::MADD, exPkg::MADDU: begin
                    {predHi, predLo} = {hiModel, loModel} + prod;
                    predCount = mulLatency;
                end
                exPkg::MSUB, exPkg::MSUBU: begin
                    {predHi, predLo} = {hiModel, loModel} - prod;
                    predCount = mulLatency;
                end
                exPkg::DIV, exPkg::DIVU: begin
                    if (rt != 0) begin
                        sQuot = longint'($signed(rs)) / longint'($signed(rt));
                        sRem = longint'($signed(rs)) % longint'($signed(rt));
                        predLo = unsignedOp ? rs / rt : exPkg::wordT'(sQuot);
                        predHi = unsignedOp ? rs % rt : exPkg::wordT'(sRem);
                        predCount = divLatency;
                    end
                end
                exPkg::MTHI: predHi = rs;
                exPkg::MTLO: predLo = rs;
                default: ;
            endcase
        end
    endtask

    task automatic commitModel();
        if (clr) begin
            expMem = '0;
        end else if (!stall) begin
            expMem = predicted;
        end
        hiModel = predHi;
        loModel = predLo;
        countModel = predCount;
    endtask

    // One instruction per cycle, driven 1 ns after the edge
    task automatic issue(input exPkg::exInT in);
        @(posedge clk);
        commitModel();
        #1;
        exIn = in;
        fwdMem = curFwdMem;
        fwdWb = curFwdWb;
        stall = curStall;
        clr = curClr;
        disMulDiv = curDis;
        predict();
    endtask

    exMemMatches: assert property (@(negedge clk) disable iff (!checkOn) exMem == expMem)
        else begin
            exMemErrors++;
            $display("CHECK FAILED at %0t: exMem %h, expected %h", $time, exMem, expMem);
        end

    busyMatches: assert property (@(negedge clk) disable iff (!checkOn) mdBusy == predBusy)
        else begin
            busyErrors++;
            $display("CHECK FAILED at %0t: mdBusy %b, expected %b", $time, mdBusy, predBusy);
        end

    task automatic sweepAluOps();
        exPkg::exInT in;
        exPkg::instrT op;
        for (int k = 1; k <= exPkg::SW; k++) begin
            op = exPkg::instrT'(k);
            if (classOf(op) != exPkg::MULDIV) begin
                for (int r = 0; r < aluReps; r++) begin
                    in = buildIn(op, randBits(32), randBits(32), 16'(randBits(16)));
                    in.tNew = exPkg::tNewT'(randBits(2));
                    issue(in);
                end
            end
        end
        issue(buildIn(exPkg::CLO, 32'hfff0_1234, 32'h0, 16'h0));
        issue(buildIn(exPkg::CLZ, 32'h0000_8000, 32'h0, 16'h0));
        issue(buildIn(exPkg::CLZ, 32'h0, 32'h0, 16'h0));
    endtask

    task automatic provokeExceptions();
        exPkg::exInT in;
        issue(buildIn(exPkg::ADD, 32'h7fff_ffff, 32'h1, 16'h0));
        issue(buildIn(exPkg::ADDU, 32'h7fff_ffff, 32'h1, 16'h0));
        issue(buildIn(exPkg::ADDI, 32'h7fff_fff0, 32'h0, 16'h0010));
        issue(buildIn(exPkg::SUB, 32'h8000_0000, 32'h1, 16'h0));
        issue(buildIn(exPkg::LW, 32'h7fff_ff00, 32'h0, 16'h0100));
        issue(buildIn(exPkg::SW, 32'h8000_0000, 32'h0, 16'hfff0));
        // Earlier stage exception wins
        in = buildIn(exPkg::ADD, 32'h7fff_ffff, 32'h1, 16'h0);
        in.exc = 5'd10;
        issue(in);
    endtask

    task automatic forwardOperands();
        exPkg::exInT in;
        curFwdMem.addr = 5'd8;
        curFwdMem.data = 32'h1111_1111;
        curFwdWb.addr = 5'd8;
        curFwdWb.data = 32'h2222_2222;
        issue(buildIn(exPkg::ADDU, 32'h5, 32'h7, 16'h0));
        curFwdWb.addr = 5'd9;
        issue(buildIn(exPkg::SW, 32'h100, 32'h7, 16'h4));
        curFwdMem.addr = 5'd0;
        curFwdWb.addr = 5'd0;
        in = buildIn(exPkg::ADDU, 32'h30, 32'h40, 16'h0);
        in.addrRs = 5'd0;
        in.addrRt = 5'd0;
        issue(in);
        curFwdMem = '0;
        curFwdWb = '0;
    endtask

    task automatic mdOp(input exPkg::instrT op, input exPkg::wordT a, input exPkg::wordT b);
        int waited;
        issue(buildIn(op, a, b, 16'h0));
        waited = 0;
        @(negedge clk);
        while (mdBusy && waited < busyWaitMax) begin
            issue(buildIn(exPkg::NOP, 32'h0, 32'h0, 16'h0));
            waited++;
            @(negedge clk);
        end
        if (mdBusy) begin
            otherErrors++;
            $display("mdBusy still high %0d cycles after %s", waited, op.name());
        end
        issue(buildIn(exPkg::MFHI, 32'h0, 32'h0, 16'h0));
        issue(buildIn(exPkg::MFLO, 32'h0, 32'h0, 16'h0));
    endtask

    task automatic sequenceMulDiv();
        mdOp(exPkg::MULT, 32'hffff_fff6, 32'h0000_0007);
        mdOp(exPkg::MULTU, 32'hffff_fff6, 32'h0000_0007);
        mdOp(exPkg::DIV, 32'hffff_ff9c, 32'h0000_0007);
        mdOp(exPkg::DIVU, randBits(32), randBits(16) | 32'h1);
        mdOp(exPkg::MADD, randBits(32), randBits(32));
        mdOp(exPkg::MADDU, randBits(32), randBits(32));
        mdOp(exPkg::MSUB, randBits(32), randBits(32));
        mdOp(exPkg::MSUBU, randBits(32), randBits(32));
        mdOp(exPkg::MTHI, 32'hcafe_0001, 32'h0);
        mdOp(exPkg::MTLO, 32'hcafe_0002, 32'h0);
        mdOp(exPkg::DIV, 32'h0000_1234, 32'h0);
        curDis = 1'b1;
        issue(buildIn(exPkg::MULT, 32'h3, 32'h5, 16'h0));
        curDis = 1'b0;
        mdOp(exPkg::NOP, 32'h0, 32'h0);
        // Read back during the countdown
        issue(buildIn(exPkg::MULT, 32'h1234_5678, 32'h9abc_def0, 16'h0));
        mdOp(exPkg::MFHI, 32'h0, 32'h0);
    endtask

    task automatic stallAndClear();
        exPkg::exInT in;
        issue(buildIn(exPkg::ADDU, 32'h1, 32'h2, 16'h0));
        curStall = 1'b1;
        issue(buildIn(exPkg::XOR, 32'h3, 32'h4, 16'h0));
        issue(buildIn(exPkg::OR, 32'h5, 32'h6, 16'h0));
        curClr = 1'b1;
        issue(buildIn(exPkg::AND, 32'h7, 32'h8, 16'h0));
        curStall = 1'b0;
        issue(buildIn(exPkg::SUB, 32'h9, 32'ha, 16'h0));
        curClr = 1'b0;
        in = buildIn(exPkg::ADDU, 32'hb, 32'hc, 16'h0);
        in.tNew = 2'd0;
        issue(in);
        in.tNew = 2'd3;
        issue(in);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        lfsrState = 32'd25;
        exMemErrors = 0;
        busyErrors = 0;
        otherErrors = 0;
        checkOn = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        disMulDiv = 1'b0;
        exIn = '0;
        fwdMem = '0;
        fwdWb = '0;
        curFwdMem = '0;
        curFwdWb = '0;
        curStall = 1'b0;
        curClr = 1'b0;
        curDis = 1'b0;
        hiModel = '0;
        loModel = '0;
        countModel = 0;
        expMem = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        predict();
        checkOn = 1'b1;

        sweepAluOps();
        provokeExceptions();
        forwardOperands();
        sequenceMulDiv();
        stallAndClear();
        issue(buildIn(exPkg::NOP, 32'h0, 32'h0, 16'h0));
        issue(buildIn(exPkg::NOP, 32'h0, 32'h0, 16'h0));
        @(negedge clk);
        #1;

        $display("Errors: exMem %0d, mdBusy %0d, other %0d", exMemErrors, busyErrors, otherErrors);
        if (exMemErrors + busyErrors + otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/exPkg.sv
src/operandForward.sv
src/aluUnit.sv
src/mulDivUnit.sv
src/exStageReg.sv
src/exStage.sv
bench/exStageTb.sv

//--- src/aluUnit.sv
`timescale 1ns/1ps
`include "exCfg.svh"

module aluUnit (
    input  exPkg::instrT   instr,
    input  exPkg::iFuncT   iFunc,
    input  exPkg::wordT    rsVal,
    input  exPkg::wordT    rtVal,
    input  logic [15:0]    imm16,
    input  logic [4:0]     shamt,
    output exPkg::wordT    result,
    output exPkg::excCodeT exc
);

    typedef enum logic [3:0] {
        OP_ZERO, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT,
        OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_CLO, OP_CLZ
    } aluOpT;

    aluOpT aluOp;
    logic isMem;
    logic zeroExt;
    logic constShift;
    logic [4:0] shiftAmt;
    exPkg::wordT extImm;
    exPkg::wordT opB;
    logic [`EX_WORD_W:0] sumWide;
    logic [`EX_WORD_W:0] difWide;
    logic sumOvf;
    logic difOvf;

    // Counts identical bits from the MSB down
    function automatic exPkg::wordT countLeading(input exPkg::wordT value, input logic bitVal);
        exPkg::wordT count;
        logic stop;
        count = '0;
        stop = 1'b0;
        for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
            if (!stop && value[i] == bitVal) begin
                count = count + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        return count;
    endfunction

    assign isMem = (iFunc == exPkg::MEM_R) || (iFunc == exPkg::MEM_W);

    always_comb begin
        case (instr)
            exPkg::ADD, exPkg::ADDU, exPkg::ADDI, exPkg::ADDIU: aluOp = OP_ADD;
            exPkg::SUB, exPkg::SUBU:   aluOp = OP_SUB;
            exPkg::AND, exPkg::ANDI:   aluOp = OP_AND;
            exPkg::OR, exPkg::ORI:     aluOp = OP_OR;
            exPkg::XOR, exPkg::XORI:   aluOp = OP_XOR;
            exPkg::NOR:                aluOp = OP_NOR;
            exPkg::SLT, exPkg::SLTI:   aluOp = OP_SLT;
            exPkg::SLTU, exPkg::SLTIU: aluOp = OP_SLTU;
            exPkg::SLL, exPkg::SLLV:   aluOp = OP_SLL;
            exPkg::SRL, exPkg::SRLV:   aluOp = OP_SRL;
            exPkg::SRA, exPkg::SRAV:   aluOp = OP_SRA;
            exPkg::LUI:                aluOp = OP_LUI;
            exPkg::CLO:                aluOp = OP_CLO;
            exPkg::CLZ:                aluOp = OP_CLZ;
            default:                   aluOp = OP_ZERO;
        endcase
        // Loads and stores only form the address
        if (isMem) begin
            aluOp = OP_ADD;
        end
    end

    // Logical immediates and LUI take the immediate unsigned
    assign zeroExt = !isMem &&
        (instr inside {exPkg::ANDI, exPkg::ORI, exPkg::XORI, exPkg::LUI});
    assign extImm = zeroExt ? {{(`EX_WORD_W-16){1'b0}}, imm16} :
                              {{(`EX_WORD_W-16){imm16[15]}}, imm16};

    assign opB = (iFunc == exPkg::ALU_I || isMem) ? extImm :
                 (iFunc == exPkg::ALU_R) ? rtVal : '0;

    assign constShift = instr inside {exPkg::SLL, exPkg::SRL, exPkg::SRA};
    assign shiftAmt = constShift ? shamt : rsVal[4:0];

    always_comb begin
        case (aluOp)
            OP_ADD:  result = rsVal + opB;
            OP_SUB:  result = rsVal - opB;
            OP_AND:  result = rsVal & opB;
            OP_OR:   result = rsVal | opB;
            OP_XOR:  result = rsVal ^ opB;
            OP_NOR:  result = ~(rsVal | opB);
            OP_SLT:  result = exPkg::wordT'($signed(rsVal) < $signed(opB));
            OP_SLTU: result = exPkg::wordT'(rsVal < opB);
            OP_SLL:  result = opB << shiftAmt;
            OP_SRL:  result = opB >> shiftAmt;
            OP_SRA:  result = $signed(opB) >>> shiftAmt;
            OP_LUI:  result = {opB[15:0], 16'b0};
            OP_CLO:  result = countLeading(rsVal, 1'b1);
            OP_CLZ:  result = countLeading(rsVal, 1'b0);
            default: result = '0;
        endcase
    end

    // Sign bit copied into bit 32, overflow when the top two bits differ
    assign sumWide = {rsVal[`EX_WORD_W-1], rsVal} + {opB[`EX_WORD_W-1], opB};
    assign difWide = {rsVal[`EX_WORD_W-1], rsVal} - {opB[`EX_WORD_W-1], opB};
    assign sumOvf = sumWide[`EX_WORD_W] != sumWide[`EX_WORD_W-1];
    assign difOvf = difWide[`EX_WORD_W] != difWide[`EX_WORD_W-1];

    always_comb begin
        if (iFunc == exPkg::MEM_R && sumOvf) begin
            exc = `EX_EXC_ADEL;
        end else if (iFunc == exPkg::MEM_W && sumOvf) begin
            exc = `EX_EXC_ADES;
        end else if ((instr == exPkg::ADD || instr == exPkg::ADDI) && sumOvf) begin
            exc = `EX_EXC_OV;
        end else if (instr == exPkg::SUB && difOvf) begin
            exc = `EX_EXC_OV;
        end else begin
            exc = '0;
        end
    end

endmodule

//--- src/exCfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Datapath widths
`define EX_WORD_W 32
`define EX_REG_ADDR_W 5
`define EX_TNEW_W 2

// Busy cycles that follow the accepting edge
`define EX_MUL_CYCLES 5
`define EX_DIV_CYCLES 10

// Exception cause codes
`define EX_EXC_ADEL 5'd4
`define EX_EXC_ADES 5'd5
`define EX_EXC_OV 5'd12

`endif

//--- src/exPkg.sv
`include "exCfg.svh"

package exPkg;

    typedef logic [`EX_WORD_W-1:0] wordT;
    typedef logic [`EX_REG_ADDR_W-1:0] regAddrT;
    // Zero means no exception
    typedef logic [4:0] excCodeT;
    typedef logic [`EX_TNEW_W-1:0] tNewT;

    typedef enum logic [5:0] {
        NOP, ADD, ADDU, ADDI, ADDIU, SUB, SUBU,
        AND, ANDI, OR, ORI, XOR, XORI, NOR,
        SLT, SLTI, SLTU, SLTIU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        LUI, CLO, CLZ,
        MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
        MFHI, MFLO, MTHI, MTLO,
        LW, SW
    } instrT;

    typedef enum logic [2:0] {
        ALU_R, ALU_I, MEM_R, MEM_W, MULDIV, OTHER
    } iFuncT;

    // Decoded instruction entering the stage
    typedef struct packed {
        instrT   instr;
        iFuncT   iFunc;
        wordT    pc;
        excCodeT exc;
        logic    branchDelay;
        wordT    dataRs;
        wordT    dataRt;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        regAddrT addrRs;
        regAddrT addrRt;
        regAddrT addrRd;
        regAddrT regWriteAddr;
        wordT    regWriteData;
        tNewT    tNew;
    } exInT;

    // One bypass source from a later stage
    typedef struct packed {
        regAddrT addr;
        wordT    data;
    } fwdT;

    typedef struct packed {
        instrT   instr;
        iFuncT   iFunc;
        wordT    pc;
        excCodeT exc;
        logic    branchDelay;
        wordT    exOut;
        regAddrT addrRt;
        wordT    dataRt;
        regAddrT addrRd;
        regAddrT regWriteAddr;
        wordT    regWriteData;
        tNewT    tNew;
    } exOutT;

endpackage

//--- src/exStage.sv
`timescale 1ns/1ps

module exStage (
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  logic         clr,
    input  logic         disMulDiv,
    input  exPkg::exInT  exIn,
    input  exPkg::fwdT   fwdMem,
    input  exPkg::fwdT   fwdWb,
    output exPkg::exOutT exMem,
    output logic         mdBusy
);

    exPkg::wordT rsVal;
    exPkg::wordT rtVal;
    exPkg::wordT aluOut;
    exPkg::excCodeT aluExc;
    exPkg::wordT mdOut;
    exPkg::wordT exOut;
    exPkg::wordT regWriteData;
    logic isMoveFrom;

    operandForward fwd_i (
        .addrRs (exIn.addrRs),
        .addrRt (exIn.addrRt),
        .dataRs (exIn.dataRs),
        .dataRt (exIn.dataRt),
        .fwdMem (fwdMem),
        .fwdWb  (fwdWb),
        .rsVal  (rsVal),
        .rtVal  (rtVal)
    );

    aluUnit alu_i (
        .instr  (exIn.instr),
        .iFunc  (exIn.iFunc),
        .rsVal  (rsVal),
        .rtVal  (rtVal),
        .imm16  (exIn.imm16),
        .shamt  (exIn.shamt),
        .result (aluOut),
        .exc    (aluExc)
    );

    mulDivUnit mulDiv_i (
        .clk    (clk),
        .reset  (reset),
        .enable (!disMulDiv),
        .instr  (exIn.instr),
        .rsVal  (rsVal),
        .rtVal  (rtVal),
        .busy   (mdBusy),
        .mdOut  (mdOut)
    );

    // HI/LO reads come from the multiply/divide unit, all else from the ALU
    assign isMoveFrom = (exIn.instr == exPkg::MFHI) || (exIn.instr == exPkg::MFLO);
    assign exOut = isMoveFrom ? mdOut : aluOut;

    // Non-ALU instructions keep the write data decided upstream
    always_comb begin
        if (isMoveFrom) begin
            regWriteData = mdOut;
        end else if (exIn.iFunc == exPkg::ALU_R || exIn.iFunc == exPkg::ALU_I) begin
            regWriteData = aluOut;
        end else begin
            regWriteData = exIn.regWriteData;
        end
    end

    exStageReg stageReg_i (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .clr          (clr),
        .stageIn      (exIn),
        .aluExc       (aluExc),
        .exOut        (exOut),
        .rtVal        (rtVal),
        .regWriteData (regWriteData),
        .exMem        (exMem)
    );

endmodule

//--- src/exStageReg.sv
`timescale 1ns/1ps

module exStageReg (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           clr,
    input  exPkg::exInT    stageIn,
    input  exPkg::excCodeT aluExc,
    input  exPkg::wordT    exOut,
    input  exPkg::wordT    rtVal,
    input  exPkg::wordT    regWriteData,
    output exPkg::exOutT   exMem
);

    exPkg::exOutT nextMem;

    always_comb begin
        nextMem.instr = stageIn.instr;
        nextMem.iFunc = stageIn.iFunc;
        nextMem.pc = stageIn.pc;
        // An earlier stage's exception takes precedence
        nextMem.exc = (stageIn.exc != '0) ? stageIn.exc : aluExc;
        nextMem.branchDelay = stageIn.branchDelay;
        nextMem.exOut = exOut;
        nextMem.addrRt = stageIn.addrRt;
        // Forwarded store data
        nextMem.dataRt = rtVal;
        nextMem.addrRd = stageIn.addrRd;
        nextMem.regWriteAddr = stageIn.regWriteAddr;
        nextMem.regWriteData = regWriteData;
        // One cycle closer to ready, floored at 0
        nextMem.tNew = (stageIn.tNew != '0) ? stageIn.tNew - 1'b1 : '0;
    end

    // Clear beats stall
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            exMem <= '0;
        end else if (!stall) begin
            exMem <= nextMem;
        end
    end

    clrFlushes: assert property (@(posedge clk) disable iff (reset) clr |=> exMem == '0)
        else $error("exStageReg: exMem not flushed after clr");

endmodule

//--- src/mulDivUnit.sv
`timescale 1ns/1ps
`include "exCfg.svh"

module mulDivUnit (
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  exPkg::instrT instr,
    input  exPkg::wordT  rsVal,
    input  exPkg::wordT  rtVal,
    output logic         busy,
    output exPkg::wordT  mdOut
);

    localparam int countW = $clog2(`EX_DIV_CYCLES + 1);
    localparam logic [countW-1:0] mulCount = `EX_MUL_CYCLES;
    localparam logic [countW-1:0] divCount = `EX_DIV_CYCLES;

    exPkg::wordT hi;
    exPkg::wordT lo;
    logic [countW-1:0] count;
    logic isMdOp;
    logic unsignedOp;
    logic [2*`EX_WORD_W-1:0] extRs;
    logic [2*`EX_WORD_W-1:0] extRt;
    logic [2*`EX_WORD_W-1:0] product;
    exPkg::wordT quotient;
    exPkg::wordT remainder;

    assign isMdOp = instr inside {exPkg::MULT, exPkg::MULTU, exPkg::DIV, exPkg::DIVU,
                                  exPkg::MADD, exPkg::MADDU, exPkg::MSUB, exPkg::MSUBU};
    assign unsignedOp = instr inside {exPkg::MULTU, exPkg::DIVU, exPkg::MADDU, exPkg::MSUBU};

    // Busy already in the accepting cycle so the hazard unit stalls in time
    assign busy = (count != '0) || isMdOp;

    // Low 64 bits of the extended product are right for both signednesses
    assign extRs = unsignedOp ? {{`EX_WORD_W{1'b0}}, rsVal} : {{`EX_WORD_W{rsVal[`EX_WORD_W-1]}}, rsVal};
    assign extRt = unsignedOp ? {{`EX_WORD_W{1'b0}}, rtVal} : {{`EX_WORD_W{rtVal[`EX_WORD_W-1]}}, rtVal};
    assign product = extRs * extRt;

    always_comb begin
        if (unsignedOp) begin
            quotient = rsVal / rtVal;
            remainder = rsVal % rtVal;
        end else begin
            quotient = $signed(rsVal) / $signed(rtVal);
            remainder = $signed(rsVal) % $signed(rtVal);
        end
    end

    always_comb begin
        if (busy) begin
            mdOut = '0;
        end else if (instr == exPkg::MFHI) begin
            mdOut = hi;
        end else if (instr == exPkg::MFLO) begin
            mdOut = lo;
        end else begin
            mdOut = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
            count <= '0;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else if (enable) begin
            case (instr)
                exPkg::MULT, exPkg::MULTU: begin
                    {hi, lo} <= product;
                    count <= mulCount;
                end
                exPkg::MADD, exPkg::MADDU: begin
                    {hi, lo} <= {hi, lo} + product;
                    count <= mulCount;
                end
                exPkg::MSUB, exPkg::MSUBU: begin
                    {hi, lo} <= {hi, lo} - product;
                    count <= mulCount;
                end
                exPkg::DIV, exPkg::DIVU: begin
                    // Divide by zero is dropped
                    if (rtVal != '0) begin
                        hi <= remainder;
                        lo <= quotient;
                        count <= divCount;
                    end
                end
                exPkg::MTHI: hi <= rsVal;
                exPkg::MTLO: lo <= rsVal;
                default: ;
            endcase
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (reset) count <= divCount)
        else $error("mulDivUnit: countdown %0d above divide latency", count);

endmodule

//--- src/operandForward.sv
`timescale 1ns/1ps

module operandForward (
    input  exPkg::regAddrT addrRs,
    input  exPkg::regAddrT addrRt,
    input  exPkg::wordT    dataRs,
    input  exPkg::wordT    dataRt,
    input  exPkg::fwdT     fwdMem,
    input  exPkg::fwdT     fwdWb,
    output exPkg::wordT    rsVal,
    output exPkg::wordT    rtVal
);

    typedef enum logic [1:0] {
        SRC_DECODED,
        SRC_MEM,
        SRC_WB
    } srcSelT;

    srcSelT rsSel;
    srcSelT rtSel;

    // Memory stage holds the newer value so it is checked first
    function automatic srcSelT pickSource(
        input exPkg::regAddrT addr,
        input exPkg::fwdT     mem,
        input exPkg::fwdT     wb
    );
        if (mem.addr == addr && mem.addr != '0) begin
            return SRC_MEM;
        end
        if (wb.addr == addr && wb.addr != '0) begin
            return SRC_WB;
        end
        return SRC_DECODED;
    endfunction

    function automatic exPkg::wordT selectValue(
        input srcSelT      sel,
        input exPkg::wordT decoded
    );
        case (sel)
            SRC_MEM: return fwdMem.data;
            SRC_WB:  return fwdWb.data;
            default: return decoded;
        endcase
    endfunction

    always_comb begin
        rsSel = pickSource(addrRs, fwdMem, fwdWb);
        rtSel = pickSource(addrRt, fwdMem, fwdWb);
        rsVal = selectValue(rsSel, dataRs);
        rtVal = selectValue(rtSel, dataRt);
    end

    // $zero reads the decoded value whatever a later stage claims to write
    always_comb begin
        assert final ((addrRs != '0 || rsVal == dataRs) &&
                      (addrRt != '0 || rtVal == dataRt))
        else $error("operandForward: register 0 took a bypass value");
    end

endmodule
